// File: axil_pkg.sv
`include "trig_cfg.svh"

package axil_pkg;

    // Byte address, data word and write strobes of the register port
    typedef logic [7:0]  axil_addr_t;
    typedef logic [31:0] axil_data_t;
    typedef logic [3:0]  axil_strb_t;

    // Write and read response codes
    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_SLVERR = 2'b10
    } axil_resp_t;

    // Threshold bank, one write-only word per beam
    localparam axil_addr_t THRESH_BASE = 8'h00;

    // Control word with self-clearing pulses
    localparam axil_addr_t CTRL = 8'h10;

    // Scaler bank, one read-only word per beam
    localparam axil_addr_t SCALER_BASE = 8'h20;

    // Bytes covered by a per-beam bank
    localparam axil_addr_t BANK_BYTES = axil_addr_t'(4 * `TRIG_NUM_BEAMS);

    // Bits of the control word
    localparam int CTRL_UPDATE_BIT = 0;
    localparam int CTRL_CLEAR_BIT  = 1;

endpackage

// File: beam_trigger_chk.sv
`timescale 1ns/1ps

module beam_trigger_chk (
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    input  logic                 awready_i,
    input  logic                 wready_i,
    input  logic                 arready_i,
    input  logic                 bvalid_i,
    input  logic                 bready_i,
    input  logic                 rvalid_i,
    input  logic                 rready_i,
    input  axil_pkg::axil_data_t rdata_i,
    input  axil_pkg::axil_resp_t rresp_i,
    input  logic                 update_i
);
    // Failed assertions, read back by the testbench at the end
    int fail_cnt;

    initial fail_cnt = 0;

    // Sync reset, so outputs are low one edge after reset is seen
    reset_quiet: assert property (@(posedge clk_i)
        !rst_n_i |=> !(awready_i || wready_i || arready_i || bvalid_i || rvalid_i))
    else begin
        $error("AXI ready or valid output high during reset");
        fail_cnt++;
    end

    // Write response waits for the master
    bvalid_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        bvalid_i && !bready_i |=> bvalid_i)
    else begin
        $error("bvalid dropped before bready");
        fail_cnt++;
    end

    // Read data frozen while the master stalls
    rvalid_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        rvalid_i && !rready_i |=> rvalid_i && $stable(rdata_i) && $stable(rresp_i))
    else begin
        $error("rvalid, rdata or rresp changed before rready");
        fail_cnt++;
    end

    // Update strobe is a single pulse
    update_pulse: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        update_i |=> !update_i)
    else begin
        $error("update pulse longer than one cycle");
        fail_cnt++;
    end

endmodule

// File: beam_trigger_top.sv
`timescale 1ns/1ps
`include "trig_cfg.svh"

module beam_trigger_top (
    input  logic                                          clk_i,
    input  logic                                          rst_n_i,
    input  trig_pkg::beam_sample_t [`TRIG_NUM_BEAMS-1:0]  beam_in0_i,
    input  trig_pkg::beam_sample_t [`TRIG_NUM_BEAMS-1:0]  beam_in1_i,
    output logic [`TRIG_NUM_BEAMS-1:0]                    trigger_o,
    input  axil_pkg::axil_addr_t                          s_awaddr_i,
    input  logic                                          s_awvalid_i,
    output logic                                          s_awready_o,
    input  axil_pkg::axil_data_t                          s_wdata_i,
    input  axil_pkg::axil_strb_t                          s_wstrb_i,
    input  logic                                          s_wvalid_i,
    output logic                                          s_wready_o,
    output axil_pkg::axil_resp_t                          s_bresp_o,
    output logic                                          s_bvalid_o,
    input  logic                                          s_bready_i,
    input  axil_pkg::axil_addr_t                          s_araddr_i,
    input  logic                                          s_arvalid_i,
    output logic                                          s_arready_o,
    output axil_pkg::axil_data_t                          s_rdata_o,
    output axil_pkg::axil_resp_t                          s_rresp_o,
    output logic                                          s_rvalid_o,
    input  logic                                          s_rready_i
);
    import trig_pkg::*;

    // Threshold loading, shared by both beam pairs
    thresh_t                    thresh;
    logic [`TRIG_NUM_BEAMS-1:0] thresh_ce;
    logic                       update;
    logic                       clear;

    // Flat trigger bus, one bit per beam
    wire [`TRIG_NUM_BEAMS-1:0]  trig_bus;

    scaler_t [`TRIG_NUM_BEAMS-1:0] counts;

    assign trigger_o = trig_bus;

    // Pair p carries beams 2p and 2p+1
    for (genvar p = 0; p < `TRIG_NUM_PAIRS; p++) begin : g_pair
        dual_beam_threshold u_pair (
            .clk_i        (clk_i),
            .rst_n_i      (rst_n_i),
            .beam_a_in0_i (beam_in0_i[2*p]),
            .beam_a_in1_i (beam_in1_i[2*p]),
            .beam_b_in0_i (beam_in0_i[2*p+1]),
            .beam_b_in1_i (beam_in1_i[2*p+1]),
            .thresh_i     (thresh),
            .thresh_ce_i  (thresh_ce[2*p +: 2]),
            .update_i     (update),
            .trigger_o    (trig_bus[2*p +: 2])
        );
    end

    trigger_scaler u_scaler (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .trigger_i (trig_bus),
        .clear_i   (clear),
        .counts_o  (counts)
    );

    thresh_axil_regs u_regs (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .s_awaddr_i  (s_awaddr_i),
        .s_awvalid_i (s_awvalid_i),
        .s_awready_o (s_awready_o),
        .s_wdata_i   (s_wdata_i),
        .s_wstrb_i   (s_wstrb_i),
        .s_wvalid_i  (s_wvalid_i),
        .s_wready_o  (s_wready_o),
        .s_bresp_o   (s_bresp_o),
        .s_bvalid_o  (s_bvalid_o),
        .s_bready_i  (s_bready_i),
        .s_araddr_i  (s_araddr_i),
        .s_arvalid_i (s_arvalid_i),
        .s_arready_o (s_arready_o),
        .s_rdata_o   (s_rdata_o),
        .s_rresp_o   (s_rresp_o),
        .s_rvalid_o  (s_rvalid_o),
        .s_rready_i  (s_rready_i),
        .counts_i    (counts),
        .thresh_o    (thresh),
        .thresh_ce_o (thresh_ce),
        .update_o    (update),
        .clear_o     (clear)
    );

endmodule

// File: dual_beam_threshold.sv
`timescale 1ns/1ps
`include "trig_cfg.svh"

module dual_beam_threshold (
    input  logic                   clk_i,
    input  logic                   rst_n_i,
    input  trig_pkg::beam_sample_t beam_a_in0_i,
    input  trig_pkg::beam_sample_t beam_a_in1_i,
    input  trig_pkg::beam_sample_t beam_b_in0_i,
    input  trig_pkg::beam_sample_t beam_b_in1_i,
    input  trig_pkg::thresh_t      thresh_i,
    input  logic [1:0]             thresh_ce_i,
    input  logic                   update_i,
    output logic [1:0]             trigger_o
);
    import trig_pkg::*;

    // Index 0 is beam A, index 1 is beam B
    beam_sample_t [1:0] half0;
    beam_sample_t [1:0] half1;

    // Registered sum T and the one before it
    beam_sum_t [1:0] sum_q;
    beam_sum_t [1:0] prev_q;

    // Staging and active thresholds
    thresh_t [1:0] staged_q;
    thresh_t [1:0] active_q;

    // Two-tap sum, combinational from the sum registers
    acc_t [1:0] acc;

    // Two full-scale sums can exceed an all-ones threshold
    // so the compare stays off until the first update
    logic armed_q;

    assign half0 = {beam_b_in0_i, beam_a_in0_i};
    assign half1 = {beam_b_in1_i, beam_a_in1_i};

    always_comb begin
        for (int b = 0; b < 2; b++) begin
            acc[b] = acc_t'(sum_q[b]) + acc_t'(prev_q[b]);
        end
    end

    // Stage 1 adds the halves, stage 2 compares
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            sum_q     <= '0;
            prev_q    <= '0;
            trigger_o <= '0;
        end else begin
            for (int b = 0; b < 2; b++) begin
                sum_q[b]  <= beam_sum_t'(half0[b]) + beam_sum_t'(half1[b]);
                prev_q[b] <= sum_q[b];
                // Exclusive compare, equal to threshold does not fire
                trigger_o[b] <= armed_q && (acc[b] > acc_t'(active_q[b]));
            end
        end
    end

    // Per-beam staging, common update into the active set
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            staged_q <= '1;
            active_q <= '1;
        end else begin
            for (int b = 0; b < 2; b++) begin
                if (thresh_ce_i[b]) begin
                    staged_q[b] <= thresh_i;
                end
                // Takes the staged value from before this edge
                if (update_i) begin
                    active_q[b] <= staged_q[b];
                end
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            armed_q <= 1'b0;
        end else if (update_i) begin
            armed_q <= 1'b1;
        end
    end

endmodule

// File: list.f
+incdir+.
trig_pkg.sv
axil_pkg.sv
dual_beam_threshold.sv
trigger_scaler.sv
thresh_axil_regs.sv
beam_trigger_top.sv
beam_trigger_chk.sv
tb_beam_trigger.sv

// File: tb_beam_trigger.sv
`timescale 1ns/1ps
`include "trig_cfg.svh"

module tb_beam_trigger;
    import trig_pkg::*;
    import axil_pkg::*;

    localparam int NB         = `TRIG_NUM_BEAMS;
    localparam int CLK_PERIOD = 40;
    localparam int MAX_LEN    = 40;
    localparam int THR_ONES   = (1 << `TRIG_THRESH_W) - 1;
    localparam int CNT_MAX    = (1 << `TRIG_SCALER_W) - 1;
    // Stream samples of all tests, plus three flush cycles per stream
    localparam int STREAM_CYCLES = 16 + 3 + 3 + 3 + MAX_LEN + 24 + 3 + 4 + 8 * 3;
    // Up to 40 register accesses, each well under 8 cycles
    localparam int AXI_CYCLES      = 40 * 8;
    localparam int WATCHDOG_CYCLES = 2 * (2 + STREAM_CYCLES + AXI_CYCLES);

    logic                  clk_i;
    logic                  rst_n_i;
    beam_sample_t [NB-1:0] beam_in0_i;
    beam_sample_t [NB-1:0] beam_in1_i;
    logic [NB-1:0]         trigger_o;
    axil_addr_t            s_awaddr_i;
    logic                  s_awvalid_i;
    logic                  s_awready_o;
    axil_data_t            s_wdata_i;
    axil_strb_t            s_wstrb_i;
    logic                  s_wvalid_i;
    logic                  s_wready_o;
    axil_resp_t            s_bresp_o;
    logic                  s_bvalid_o;
    logic                  s_bready_i;
    axil_addr_t            s_araddr_i;
    logic                  s_arvalid_i;
    logic                  s_arready_o;
    axil_data_t            s_rdata_o;
    axil_resp_t            s_rresp_o;
    logic                  s_rvalid_o;
    logic                  s_rready_i;

    // Reference model state
    int m_staged [NB];
    int m_active [NB];
    int m_count  [NB];
    bit m_armed;

    // Stimulus of the current stream and the triggers it produced
    beam_sample_t stim0 [MAX_LEN][NB];
    beam_sample_t stim1 [MAX_LEN][NB];
    int seen [NB];

    int     errors;
    int     checks;
    int     asserts;
    integer seed;

    beam_trigger_top dut_i (.*);

    bind thresh_axil_regs beam_trigger_chk u_chk (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .awready_i (s_awready_o),
        .wready_i  (s_wready_o),
        .arready_i (s_arready_o),
        .bvalid_i  (s_bvalid_o),
        .bready_i  (s_bready_i),
        .rvalid_i  (s_rvalid_o),
        .rready_i  (s_rready_i),
        .rdata_i   (s_rdata_o),
        .rresp_i   (s_rresp_o),
        .update_i  (update_o)
    );

    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    task automatic compare_value(input string name, input int expected, input int actual);
        checks++;
        if (expected != actual) begin
            errors++;
            $display("ERROR %s: expected %0d, actual %0d", name, expected, actual);
        end
    endtask

    task automatic axi_write(input axil_addr_t addr, input int data, output axil_resp_t resp);
        @(posedge clk_i);
        s_awaddr_i  <= addr;
        s_wdata_i   <= data;
        s_wstrb_i   <= 4'hf;
        s_awvalid_i <= 1'b1;
        s_wvalid_i  <= 1'b1;
        // Ready is a one-cycle pulse, the next edge is the handshake
        do begin
            @(negedge clk_i);
        end while (!s_awready_o);
        // Address and data ready rise together
        compare_value("write wready with awready", 1, int'(s_wready_o));
        @(posedge clk_i);
        s_awvalid_i <= 1'b0;
        s_wvalid_i  <= 1'b0;
        do begin
            @(negedge clk_i);
        end while (!s_bvalid_o);
        resp = s_bresp_o;
        // Master stalls one cycle, bvalid has to hold
        @(posedge clk_i);
        s_bready_i <= 1'b1;
        // Response completes here
        @(posedge clk_i);
        s_bready_i <= 1'b0;
    endtask

    task automatic axi_read(input axil_addr_t addr, output int data, output axil_resp_t resp);
        @(posedge clk_i);
        s_araddr_i  <= addr;
        s_arvalid_i <= 1'b1;
        do begin
            @(negedge clk_i);
        end while (!s_arready_o);
        @(posedge clk_i);
        s_arvalid_i <= 1'b0;
        do begin
            @(negedge clk_i);
        end while (!s_rvalid_o);
        data = s_rdata_o;
        resp = s_rresp_o;
        // Master stalls one cycle, rvalid and rdata have to hold
        @(posedge clk_i);
        s_rready_i <= 1'b1;
        @(posedge clk_i);
        s_rready_i <= 1'b0;
    endtask

    task automatic write_thresh(input int k, input int value);
        axil_resp_t resp;
        axi_write(axil_addr_t'(THRESH_BASE + 4 * k), value, resp);
        compare_value($sformatf("threshold write beam %0d response", k), RESP_OKAY, resp);
        m_staged[k] = value;
    endtask

    task automatic apply_update();
        axil_resp_t resp;
        axi_write(CTRL, 1 << CTRL_UPDATE_BIT, resp);
        compare_value("update write response", RESP_OKAY, resp);
        // Every staged value becomes active at once
        for (int k = 0; k < NB; k++) begin
            m_active[k] = m_staged[k];
        end
        m_armed = 1'b1;
    endtask

    task automatic clear_scalers();
        axil_resp_t resp;
        axi_write(CTRL, 1 << CTRL_CLEAR_BIT, resp);
        compare_value("scaler clear response", RESP_OKAY, resp);
        for (int k = 0; k < NB; k++) begin
            m_count[k] = 0;
        end
    endtask

    task automatic check_scalers(input string name);
        int         data;
        axil_resp_t resp;
        for (int k = 0; k < NB; k++) begin
            axi_read(axil_addr_t'(SCALER_BASE + 4 * k), data, resp);
            compare_value($sformatf("%s beam %0d response", name, k), RESP_OKAY, resp);
            compare_value($sformatf("%s beam %0d count", name, k), m_count[k], data);
        end
    endtask

    task automatic clear_stim();
        for (int i = 0; i < MAX_LEN; i++) begin
            for (int k = 0; k < NB; k++) begin
                stim0[i][k] = '0;
                stim1[i][k] = '0;
            end
        end
    endtask

    task automatic set_sample(input int i, input int k, input int a, input int b);
        stim0[i][k] = beam_sample_t'(a);
        stim1[i][k] = beam_sample_t'(b);
    endtask

    // Sum T of sample i, zero outside the stream
    function automatic int stream_sum(input int k, input int i, input int n);
        if (i < 0 || i >= n) begin
            return 0;
        end
        return int'(stim0[i][k]) + int'(stim1[i][k]);
    endfunction

    task automatic run_stream(input string name, input int n);
        int acc;
        int expected;
        for (int k = 0; k < NB; k++) begin
            seen[k] = 0;
        end
        // Three idle samples at the end flush the pipeline
        for (int j = 0; j < n + 3; j++) begin
            @(posedge clk_i);
            for (int k = 0; k < NB; k++) begin
                if (j < n) begin
                    beam_in0_i[k] <= stim0[j][k];
                    beam_in1_i[k] <= stim1[j][k];
                end else begin
                    beam_in0_i[k] <= '0;
                    beam_in1_i[k] <= '0;
                end
            end
            @(negedge clk_i);
            for (int k = 0; k < NB; k++) begin
                // Trigger now visible belongs to samples j-2 and j-3
                acc      = stream_sum(k, j - 2, n) + stream_sum(k, j - 3, n);
                expected = (m_armed && acc > m_active[k]) ? 1 : 0;
                compare_value($sformatf("%s beam %0d cycle %0d", name, k, j),
                              expected, int'(trigger_o[k]));
                if (expected == 1 && m_count[k] < CNT_MAX) begin
                    m_count[k]++;
                end
                seen[k] += int'(trigger_o[k]);
            end
        end
    endtask

    task automatic reset_state();
        logic [31:0] rnd;
        clear_stim();
        // Full-scale random halves, nothing may fire before an update
        for (int i = 0; i < 16; i++) begin
            for (int k = 0; k < NB; k++) begin
                rnd = $random(seed);
                stim0[i][k] = rnd[16:0];
                rnd = $random(seed);
                stim1[i][k] = rnd[16:0];
            end
        end
        run_stream("reset_state", 16);
        check_scalers("reset_state scaler");
    endtask

    task automatic exclusive_compare();
        write_thresh(0, 80000);
        apply_update();
        clear_stim();
        // 40000 + 40000 equals the threshold, 40001 + 40000 exceeds it
        set_sample(0, 0, 20000, 20000);
        set_sample(1, 0, 20000, 20000);
        set_sample(2, 0, 20001, 20000);
        run_stream("exclusive_compare", 3);
        compare_value("exclusive_compare beam 0 triggers", 1, seen[0]);
    endtask

    task automatic two_step_loading();
        clear_stim();
        for (int i = 0; i < 3; i++) begin
            set_sample(i, 0, 20000, 20000);
            set_sample(i, 1, 20000, 20000);
        end
        // Staged only, beam 0 still compares against 80000
        write_thresh(0, 40000);
        run_stream("two_step_staged", 3);
        compare_value("two_step_staged beam 0 triggers", 0, seen[0]);
        write_thresh(1, 50000);
        apply_update();
        run_stream("two_step_applied", 3);
        compare_value("two_step_applied beam 0 triggers", 2, seen[0]);
        compare_value("two_step_applied beam 1 triggers", 2, seen[1]);
    endtask

    task automatic random_beam_streams();
        logic [31:0] rnd;
        for (int k = 0; k < NB; k++) begin
            write_thresh(k, 110000 + 20000 * k);
        end
        apply_update();
        clear_stim();
        // Halves below 65536 keep the two-tap sum near the thresholds
        for (int i = 0; i < MAX_LEN; i++) begin
            for (int k = 0; k < NB; k++) begin
                rnd = $random(seed);
                stim0[i][k] = rnd[15:0];
                rnd = $random(seed);
                stim1[i][k] = rnd[15:0];
            end
        end
        run_stream("random_beam_streams", MAX_LEN);
    endtask

    task automatic scaler_counts();
        clear_stim();
        for (int i = 0; i < 24; i++) begin
            for (int k = 0; k < NB; k++) begin
                set_sample(i, k, (i * 5000 + k * 1000) % 70000, (i * 3000 + k * 2000) % 60000);
            end
        end
        run_stream("scaler_counts", 24);
        check_scalers("scaler_counts");
        clear_scalers();
        check_scalers("scaler_clear");
    endtask

    task automatic unmapped_access();
        axil_addr_t bad_wr [5] = '{8'h03, 8'h14, 8'h24, 8'h30, 8'h40};
        axil_addr_t bad_rd [3] = '{8'h14, 8'h21, 8'h40};
        axil_resp_t resp;
        int         data;
        // Nonzero counts first, so a stray clear would show
        clear_stim();
        for (int i = 0; i < 3; i++) begin
            for (int k = 0; k < NB; k++) begin
                set_sample(i, k, 65000, 65000);
            end
        end
        run_stream("unmapped_preload", 3);
        // Data 3 would make a tiny threshold, or pulse update and clear, if decoded
        for (int i = 0; i < 5; i++) begin
            axi_write(bad_wr[i], 3, resp);
            compare_value($sformatf("unmapped write 0x%02h response", bad_wr[i]),
                          RESP_SLVERR, resp);
        end
        check_scalers("unmapped_write scaler");
        for (int i = 0; i < 3; i++) begin
            axi_read(bad_rd[i], data, resp);
            compare_value($sformatf("unmapped read 0x%02h response", bad_rd[i]),
                          RESP_SLVERR, resp);
        end
        // Threshold words are write-only and read as zero
        axi_read(8'h04, data, resp);
        compare_value("threshold read response", RESP_OKAY, resp);
        compare_value("threshold read data", 0, data);
        apply_update();
        clear_stim();
        for (int i = 0; i < 4; i++) begin
            for (int k = 0; k < NB; k++) begin
                set_sample(i, k, 500, 500);
            end
        end
        run_stream("unmapped_access", 4);
        for (int k = 0; k < NB; k++) begin
            compare_value($sformatf("unmapped_access beam %0d triggers", k), 0, seen[k]);
        end
    endtask

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Timeout: tests did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("RESULT: FAIL");
        $finish;
    end

    initial begin
        seed        = 7231;
        errors      = 0;
        checks      = 0;
        clk_i       = 1'b0;
        rst_n_i     = 1'b0;
        beam_in0_i  = '0;
        beam_in1_i  = '0;
        s_awaddr_i  = '0;
        s_awvalid_i = 1'b0;
        s_wdata_i   = '0;
        s_wstrb_i   = '0;
        s_wvalid_i  = 1'b0;
        s_bready_i  = 1'b0;
        s_araddr_i  = '0;
        s_arvalid_i = 1'b0;
        s_rready_i  = 1'b0;
        // Reset leaves every threshold at all ones, unarmed
        for (int k = 0; k < NB; k++) begin
            m_staged[k] = THR_ONES;
            m_active[k] = THR_ONES;
            m_count[k]  = 0;
        end
        m_armed = 1'b0;
        repeat (2) @(posedge clk_i);
        rst_n_i <= 1'b1;

        reset_state();
        exclusive_compare();
        two_step_loading();
        random_beam_streams();
        scaler_counts();
        unmapped_access();

        asserts = dut_i.u_regs.u_chk.fail_cnt;
        $display("Checks: %0d, errors: %0d, assertion failures: %0d", checks, errors, asserts);
        if (errors == 0 && asserts == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: thresh_axil_regs.sv
`timescale 1ns/1ps
`include "trig_cfg.svh"

module thresh_axil_regs (
    input  logic                                     clk_i,
    input  logic                                     rst_n_i,
    input  axil_pkg::axil_addr_t                     s_awaddr_i,
    input  logic                                     s_awvalid_i,
    output logic                                     s_awready_o,
    input  axil_pkg::axil_data_t                     s_wdata_i,
    input  axil_pkg::axil_strb_t                     s_wstrb_i,
    input  logic                                     s_wvalid_i,
    output logic                                     s_wready_o,
    output axil_pkg::axil_resp_t                     s_bresp_o,
    output logic                                     s_bvalid_o,
    input  logic                                     s_bready_i,
    input  axil_pkg::axil_addr_t                     s_araddr_i,
    input  logic                                     s_arvalid_i,
    output logic                                     s_arready_o,
    output axil_pkg::axil_data_t                     s_rdata_o,
    output axil_pkg::axil_resp_t                     s_rresp_o,
    output logic                                     s_rvalid_o,
    input  logic                                     s_rready_i,
    input  trig_pkg::scaler_t [`TRIG_NUM_BEAMS-1:0]  counts_i,
    output trig_pkg::thresh_t                        thresh_o,
    output logic [`TRIG_NUM_BEAMS-1:0]               thresh_ce_o,
    output logic                                     update_o,
    output logic                                     clear_o
);
    import axil_pkg::*;

    localparam int IDX_W = $clog2(`TRIG_NUM_BEAMS);

    // Word-aligned address inside a per-beam bank
    function automatic logic in_bank(axil_addr_t addr, axil_addr_t base);
        return (addr >= base) && (addr < base + BANK_BYTES) && (addr[1:0] == 2'b00);
    endfunction

    // Beam number of a word in a bank
    function automatic logic [IDX_W-1:0] bank_idx(axil_addr_t addr, axil_addr_t base);
        axil_addr_t offs;
        offs = addr - base;
        return offs[IDX_W+1:2];
    endfunction

    // Ready flops, one per channel
    logic wr_ready_q;
    logic rd_ready_q;
    logic wr_hs;
    logic rd_hs;

    // Write decode
    logic             wr_thresh;
    logic             wr_ctrl;
    logic [IDX_W-1:0] wr_idx;

    // Read decode
    logic             rd_thresh;
    logic             rd_ctrl;
    logic             rd_scaler;
    logic [IDX_W-1:0] rd_idx;

    assign s_awready_o = wr_ready_q;
    assign s_wready_o  = wr_ready_q;
    assign s_arready_o = rd_ready_q;

    // Address and data are taken together
    assign wr_hs = wr_ready_q && s_awvalid_i && s_wvalid_i;
    assign rd_hs = rd_ready_q && s_arvalid_i;

    assign wr_thresh = in_bank(s_awaddr_i, THRESH_BASE);
    assign wr_ctrl   = (s_awaddr_i == CTRL);
    assign wr_idx    = bank_idx(s_awaddr_i, THRESH_BASE);

    assign rd_thresh = in_bank(s_araddr_i, THRESH_BASE);
    assign rd_ctrl   = (s_araddr_i == CTRL);
    assign rd_scaler = in_bank(s_araddr_i, SCALER_BASE);
    assign rd_idx    = bank_idx(s_araddr_i, SCALER_BASE);

    // Write channel and the strobes it produces
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            wr_ready_q  <= 1'b0;
            s_bvalid_o  <= 1'b0;
            thresh_ce_o <= '0;
            update_o    <= 1'b0;
            clear_o     <= 1'b0;
        end else begin
            // Strobes last one cycle
            thresh_ce_o <= '0;
            update_o    <= 1'b0;
            clear_o     <= 1'b0;
            // One-cycle ready, held off while a response waits
            wr_ready_q <= s_awvalid_i && s_wvalid_i && !wr_ready_q && !s_bvalid_o;
            if (wr_hs) begin
                s_bvalid_o <= 1'b1;
                // Threshold needs all three low bytes
                if (wr_thresh && (&s_wstrb_i[2:0])) begin
                    thresh_ce_o[wr_idx] <= 1'b1;
                end
                if (wr_ctrl && s_wstrb_i[0]) begin
                    update_o <= s_wdata_i[CTRL_UPDATE_BIT];
                    clear_o  <= s_wdata_i[CTRL_CLEAR_BIT];
                end
            end else if (s_bready_i) begin
                s_bvalid_o <= 1'b0;
            end
        end
    end

    // Shared threshold bus and the write response
    always_ff @(posedge clk_i) begin
        if (wr_hs) begin
            thresh_o  <= s_wdata_i[`TRIG_THRESH_W-1:0];
            // Scaler bank is read-only, so writes there fail too
            s_bresp_o <= (wr_thresh || wr_ctrl) ? RESP_OKAY : RESP_SLVERR;
        end
    end

    // Read channel
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            rd_ready_q <= 1'b0;
            s_rvalid_o <= 1'b0;
        end else begin
            rd_ready_q <= s_arvalid_i && !rd_ready_q && !s_rvalid_o;
            if (rd_hs) begin
                s_rvalid_o <= 1'b1;
            end else if (s_rready_i) begin
                s_rvalid_o <= 1'b0;
            end
        end
    end

    // Read data, held until the next accepted read
    always_ff @(posedge clk_i) begin
        if (rd_hs) begin
            if (rd_scaler) begin
                s_rdata_o <= axil_data_t'(counts_i[rd_idx]);
                s_rresp_o <= RESP_OKAY;
            end else if (rd_thresh || rd_ctrl) begin
                // Write-only words read as zero
                s_rdata_o <= '0;
                s_rresp_o <= RESP_OKAY;
            end else begin
                s_rdata_o <= '0;
                s_rresp_o <= RESP_SLVERR;
            end
        end
    end

endmodule

// File: trig_cfg.svh
`ifndef TRIG_CFG_SVH
`define TRIG_CFG_SVH

// Width of one beam half-sample, unsigned power
`define TRIG_BEAM_W 17

// Threshold width, one active and one staged register per beam
`define TRIG_THRESH_W 18

// Dual-beam blocks in the stage
`define TRIG_NUM_PAIRS 2

// Each block carries a beam pair
`define TRIG_NUM_BEAMS (2 * `TRIG_NUM_PAIRS)

// Scaler counter width, saturating
`define TRIG_SCALER_W 16

`endif

// File: trig_pkg.sv
`include "trig_cfg.svh"

package trig_pkg;

    // One half of a beam power sample
    typedef logic [`TRIG_BEAM_W-1:0] beam_sample_t;

    // Sum of both halves
    // One extra bit for the carry
    typedef logic [`TRIG_BEAM_W:0] beam_sum_t;

    // Per-beam trigger threshold
    typedef logic [`TRIG_THRESH_W-1:0] thresh_t;

    // Two-tap sum T plus previous T
    // Wide enough for two full-scale sums
    typedef logic [`TRIG_BEAM_W+1:0] acc_t;

    // Trigger count of one beam
    typedef logic [`TRIG_SCALER_W-1:0] scaler_t;

endpackage

// File: trigger_scaler.sv
`timescale 1ns/1ps
`include "trig_cfg.svh"

module trigger_scaler (
    input  logic                                     clk_i,
    input  logic                                     rst_n_i,
    input  logic [`TRIG_NUM_BEAMS-1:0]               trigger_i,
    input  logic                                     clear_i,
    output trig_pkg::scaler_t [`TRIG_NUM_BEAMS-1:0]  counts_o
);
    import trig_pkg::*;

    // Counters stop here instead of wrapping
    localparam scaler_t SCALER_MAX = '1;

    // Counter is below its ceiling
    logic [`TRIG_NUM_BEAMS-1:0] room;

    always_comb begin
        for (int k = 0; k < `TRIG_NUM_BEAMS; k++) begin
            room[k] = (counts_o[k] != SCALER_MAX);
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            counts_o <= '0;
        end else if (clear_i) begin
            // Clear wins over a trigger in the same cycle
            counts_o <= '0;
        end else begin
            for (int k = 0; k < `TRIG_NUM_BEAMS; k++) begin
                if (trigger_i[k] && room[k]) begin
                    counts_o[k] <= counts_o[k] + 1'b1;
                end
            end
        end
    end

endmodule
